/* src/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

    // Default machine word width, passed down from the top level
    localparam int DATA_W = 16;

    // Default number of general registers
    localparam int REG_CNT = 8;

    // Width of a register select for a given register count
    // A single register still needs one select bit
    function automatic int reg_sel_w(input int count);
        int width;
        if (count > 1) begin
            width = $clog2(count);
        end else begin
            width = 1;
        end
        return width;
    endfunction

endpackage

/* src/isa_pkg.sv */
package isa_pkg;

    // ALU operations as issued by the decoder
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_ADC    = 4'd1,
        ALU_SUB    = 4'd2,
        ALU_SBC    = 4'd3,
        ALU_AND    = 4'd4,
        ALU_OR     = 4'd5,
        ALU_XOR    = 4'd6,
        ALU_SHL    = 4'd7,
        ALU_SHR    = 4'd8,
        ALU_ASR    = 4'd9,
        ALU_PASS_R = 4'd10
    } alu_mode_t;

    // Flag register layout
    localparam int FLAG_CNT = 5;
    localparam int FLAG_C   = 0;
    localparam int FLAG_Z   = 1;
    localparam int FLAG_N   = 2;
    localparam int FLAG_O   = 3;
    localparam int FLAG_P   = 4;

    // Top bit of a jump code marks a jump instruction
    localparam int JUMP_BIT_EN = 4;

    typedef enum logic [4:0] {
        JUMP_NONE   = 5'b00000,
        JUMP_UNCOND = 5'b10000,
        JUMP_CARRY  = 5'b10001,
        JUMP_EQUAL  = 5'b10010,
        JUMP_LT     = 5'b10011,
        JUMP_GT     = 5'b10100,
        JUMP_LE     = 5'b10101,
        JUMP_GE     = 5'b10110,
        JUMP_NE     = 5'b10111,
        JUMP_OVF    = 5'b11000,
        JUMP_PAR    = 5'b11001,
        JUMP_GTU    = 5'b11010,
        JUMP_GEU    = 5'b11011,
        JUMP_LEU    = 5'b11100
    } jump_code_t;

endpackage

/* src/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl
    import cpu_cfg_pkg::*;
#(
    parameter int REG_CNT = cpu_cfg_pkg::REG_CNT,
    localparam int SEL_W = reg_sel_w(REG_CNT)
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_submit,
    input  logic               i_flush,
    input  logic               i_next_ready,
    input  logic [SEL_W-1:0]   i_l_sel,
    input  logic [SEL_W-1:0]   i_r_sel,
    input  logic [1:0]         i_used_operands,
    input  logic [REG_CNT-1:0] i_pending_ie,
    input  logic               i_pending_valid,
    output logic               o_ready,
    output logic               o_exec_submit
);

    logic hold_valid;
    logic next_ready_q;
    logic raw_hazard;
    logic new_valid;
    logic instr_valid;

    // Operand register still waiting for write-back downstream
    // Also covers the first cycle after next-stage ready rises again
    assign raw_hazard = ((i_used_operands[0] & i_pending_ie[i_l_sel]) |
                         (i_used_operands[1] & i_pending_ie[i_r_sel])) &
                        (i_pending_valid | ~next_ready_q);

    assign new_valid   = i_submit & ~i_flush;
    assign instr_valid = new_valid | (hold_valid & ~i_submit & ~i_flush);

    // Hazard only stalls, it never drops the instruction
    assign o_exec_submit = i_next_ready & instr_valid & ~raw_hazard;
    assign o_ready       = o_exec_submit | ~instr_valid;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            hold_valid <= 1'b0;
        end else if (i_flush || o_exec_submit) begin
            hold_valid <= 1'b0;
        end else if (new_valid) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            next_ready_q <= 1'b0;
        end else begin
            next_ready_q <= i_next_ready;
        end
    end

    // A stalled instruction is remembered for the following cycle
    a_stall_is_held: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (!o_ready && !i_flush) |=> hold_valid
    );

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import cpu_cfg_pkg::*;
#(
    parameter int DATA_W  = cpu_cfg_pkg::DATA_W,
    parameter int REG_CNT = cpu_cfg_pkg::REG_CNT,
    localparam int SEL_W = reg_sel_w(REG_CNT)
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic [REG_CNT-1:0] i_we_mask,
    input  logic [DATA_W-1:0]  i_wdata,
    input  logic [SEL_W-1:0]   i_l_sel,
    input  logic [SEL_W-1:0]   i_r_sel,
    output logic [DATA_W-1:0]  o_l_data,
    output logic [DATA_W-1:0]  o_r_data
);

    logic [DATA_W-1:0] regs [REG_CNT];

    // Write-back may load several registers at once
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            regs <= '{default: '0};
        end else begin
            for (int i = 0; i < REG_CNT; i++) begin
                if (i_we_mask[i]) begin
                    regs[i] <= i_wdata;
                end
            end
        end
    end

    assign o_l_data = regs[i_l_sel];
    assign o_r_data = regs[i_r_sel];

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu
    import isa_pkg::*;
#(
    parameter int DATA_W = cpu_cfg_pkg::DATA_W
) (
    input  logic [DATA_W-1:0]   i_l,
    input  logic [DATA_W-1:0]   i_r,
    input  alu_mode_t           i_mode,
    input  logic                i_carry,
    output logic [DATA_W-1:0]   o_result,
    output logic [FLAG_CNT-1:0] o_flags
);

    localparam int SH_W = $clog2(DATA_W);
    localparam int MSB  = DATA_W - 1;

    logic [DATA_W:0]   sum;
    logic [SH_W-1:0]   shamt;
    logic [DATA_W-1:0] result;
    logic              carry;
    logic              ovf;

    assign shamt = i_r[SH_W-1:0];

    always_comb begin
        sum    = '0;
        result = '0;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (i_mode)
            ALU_ADD, ALU_ADC: begin
                sum    = {1'b0, i_l} + {1'b0, i_r} +
                         (DATA_W + 1)'(i_mode == ALU_ADC && i_carry);
                result = sum[DATA_W-1:0];
                carry  = sum[DATA_W];
                ovf    = (i_l[MSB] == i_r[MSB]) && (result[MSB] != i_l[MSB]);
            end
            ALU_SUB, ALU_SBC: begin
                // Top bit of the wide difference is the borrow
                sum    = {1'b0, i_l} - {1'b0, i_r} -
                         (DATA_W + 1)'(i_mode == ALU_SBC && i_carry);
                result = sum[DATA_W-1:0];
                carry  = sum[DATA_W];
                ovf    = (i_l[MSB] != i_r[MSB]) && (result[MSB] != i_l[MSB]);
            end
            ALU_AND:    result = i_l & i_r;
            ALU_OR:     result = i_l | i_r;
            ALU_XOR:    result = i_l ^ i_r;
            ALU_SHL:    result = i_l << shamt;
            ALU_SHR:    result = i_l >> shamt;
            ALU_ASR:    result = DATA_W'($signed(i_l) >>> shamt);
            ALU_PASS_R: result = i_r;
            default:    result = '0;
        endcase
    end

    assign o_result        = result;
    assign o_flags[FLAG_C] = carry;
    assign o_flags[FLAG_Z] = ~|result;
    assign o_flags[FLAG_N] = result[MSB];
    assign o_flags[FLAG_O] = ovf;
    // Even parity, set when the count of ones is even
    assign o_flags[FLAG_P] = ~^result;

endmodule

/* src/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
    import isa_pkg::*;
#(
    parameter int DATA_W = cpu_cfg_pkg::DATA_W
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_exec_submit,
    input  jump_code_t          i_jump_code,
    input  logic                i_jmp_predict,
    input  logic                i_pc_inc,
    input  logic                i_flags_ie,
    input  logic                i_carry_en,
    input  logic [DATA_W-1:0]   i_alu_result,
    input  logic [FLAG_CNT-1:0] i_alu_flags,
    output logic                o_carry,
    output logic [DATA_W-1:0]   o_pc,
    output logic                o_flush
);

    logic [FLAG_CNT-1:0] flags_q;
    logic [DATA_W-1:0]   pc_q;
    logic                jump_valid;
    logic                cond_met;
    logic                jump_taken;
    logic                mispredict;

    assign o_carry = flags_q[FLAG_C] & i_carry_en;

    assign jump_valid = i_jump_code[JUMP_BIT_EN];

    // Conditions look at flags from earlier instructions only
    always_comb begin
        case (i_jump_code)
            JUMP_UNCOND: cond_met = 1'b1;
            JUMP_CARRY:  cond_met = flags_q[FLAG_C];
            JUMP_EQUAL:  cond_met = flags_q[FLAG_Z];
            JUMP_LT:     cond_met = flags_q[FLAG_N];
            JUMP_GT:     cond_met = ~(flags_q[FLAG_N] | flags_q[FLAG_Z]);
            JUMP_LE:     cond_met = flags_q[FLAG_N] | flags_q[FLAG_Z];
            JUMP_GE:     cond_met = ~flags_q[FLAG_N];
            JUMP_NE:     cond_met = ~flags_q[FLAG_Z];
            JUMP_OVF:    cond_met = flags_q[FLAG_O];
            JUMP_PAR:    cond_met = flags_q[FLAG_P];
            JUMP_GTU:    cond_met = ~(flags_q[FLAG_C] | flags_q[FLAG_Z]);
            JUMP_GEU:    cond_met = ~flags_q[FLAG_C];
            JUMP_LEU:    cond_met = flags_q[FLAG_C] | flags_q[FLAG_Z];
            default:     cond_met = 1'b0;
        endcase
    end

    assign jump_taken = jump_valid & cond_met;
    assign mispredict = jump_valid & (cond_met ^ i_jmp_predict);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flags_q <= '0;
        end else if (i_exec_submit && i_flags_ie) begin
            flags_q <= i_alu_flags;
        end
    end

    // Jump target comes through the ALU
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q <= '0;
        end else if (i_exec_submit) begin
            if (jump_taken) begin
                pc_q <= i_alu_result;
            end else if (i_pc_inc) begin
                pc_q <= pc_q + DATA_W'(1);
            end
        end
    end

    // Flush the earlier stages one cycle after a wrong guess
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_flush <= 1'b0;
        end else begin
            o_flush <= mispredict & i_exec_submit;
        end
    end

    assign o_pc = pc_q;

    a_flush_after_submit: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_flush |-> $past(i_exec_submit)
    );

endmodule

/* src/exec_result_reg.sv */
`timescale 1ns/1ps

module exec_result_reg #(
    parameter int DATA_W  = cpu_cfg_pkg::DATA_W,
    parameter int REG_CNT = cpu_cfg_pkg::REG_CNT
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_exec_submit,
    input  logic [DATA_W-1:0]  i_alu_result,
    input  logic [DATA_W-1:0]  i_r_data,
    input  logic [REG_CNT-1:0] i_rf_ie,
    input  logic               i_mem_access,
    input  logic               i_mem_we,
    input  logic               i_mem_width,
    output logic [DATA_W-1:0]  o_addr,
    output logic [DATA_W-1:0]  o_data,
    output logic [REG_CNT-1:0] o_reg_ie,
    output logic               o_mem_access,
    output logic               o_mem_we,
    output logic               o_mem_width,
    output logic               o_submit
);

    // Payload fields
    always_ff @(posedge i_clk) begin
        if (i_exec_submit) begin
            o_addr      <= i_alu_result;
            o_data      <= i_mem_access ? i_r_data : i_alu_result;
            o_mem_width <= i_mem_width;
        end
    end

    // Write mask is also watched by the hazard check
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_reg_ie     <= '0;
            o_mem_access <= 1'b0;
            o_mem_we     <= 1'b0;
            o_submit     <= 1'b0;
        end else begin
            o_submit <= i_exec_submit;
            if (i_exec_submit) begin
                o_reg_ie     <= i_rf_ie;
                o_mem_access <= i_mem_access;
                o_mem_we     <= i_mem_we;
            end
        end
    end

    a_single_submit: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (o_submit && $past(o_submit)) |-> ($past(i_exec_submit) && $past(i_exec_submit, 2))
    );

endmodule

/* src/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage
    import cpu_cfg_pkg::*;
    import isa_pkg::*;
#(
    parameter int DATA_W  = cpu_cfg_pkg::DATA_W,
    parameter int REG_CNT = cpu_cfg_pkg::REG_CNT,
    localparam int SEL_W = reg_sel_w(REG_CNT)
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_submit,
    input  logic               i_flush,
    input  logic [DATA_W-1:0]  i_imm,
    input  logic               i_jmp_predict,
    input  logic               i_pc_inc,
    input  logic               i_r_bus_imm,
    input  alu_mode_t          i_alu_mode,
    input  logic               i_carry_en,
    input  logic               i_flags_ie,
    input  logic [SEL_W-1:0]   i_l_sel,
    input  logic [SEL_W-1:0]   i_r_sel,
    input  logic [REG_CNT-1:0] i_rf_ie,
    input  jump_code_t         i_jump_code,
    input  logic               i_mem_access,
    input  logic               i_mem_we,
    input  logic               i_mem_width,
    input  logic [1:0]         i_used_operands,
    input  logic               i_next_ready,
    input  logic [REG_CNT-1:0] i_reg_ie,
    input  logic [DATA_W-1:0]  i_reg_data,
    output logic               o_ready,
    output logic               o_flush,
    output logic [DATA_W-1:0]  o_exec_pc,
    output logic [DATA_W-1:0]  o_addr,
    output logic [DATA_W-1:0]  o_data,
    output logic [REG_CNT-1:0] o_reg_ie,
    output logic               o_mem_access,
    output logic               o_mem_we,
    output logic               o_mem_width,
    output logic               o_submit
);

    logic                exec_submit;
    logic [DATA_W-1:0]   l_data;
    logic [DATA_W-1:0]   r_data;
    logic [DATA_W-1:0]   alu_r;
    logic [DATA_W-1:0]   alu_result;
    logic [FLAG_CNT-1:0] alu_flags;
    logic                alu_carry;

    // Right operand comes from the immediate or from the register file
    assign alu_r = i_r_bus_imm ? i_imm : r_data;

    issue_ctrl #(
        .REG_CNT(REG_CNT)
    ) issue_ctrl_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_submit(i_submit), .i_flush(i_flush),
        .i_next_ready(i_next_ready), .i_l_sel(i_l_sel), .i_r_sel(i_r_sel),
        .i_used_operands(i_used_operands), .i_pending_ie(o_reg_ie),
        .i_pending_valid(o_submit), .o_ready(o_ready), .o_exec_submit(exec_submit)
    );

    reg_file #(
        .DATA_W(DATA_W), .REG_CNT(REG_CNT)
    ) reg_file_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_we_mask(i_reg_ie), .i_wdata(i_reg_data),
        .i_l_sel(i_l_sel), .i_r_sel(i_r_sel), .o_l_data(l_data), .o_r_data(r_data)
    );

    alu #(
        .DATA_W(DATA_W)
    ) alu_i (
        .i_l(l_data), .i_r(alu_r), .i_mode(i_alu_mode), .i_carry(alu_carry),
        .o_result(alu_result), .o_flags(alu_flags)
    );

    branch_unit #(
        .DATA_W(DATA_W)
    ) branch_unit_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_exec_submit(exec_submit),
        .i_jump_code(i_jump_code), .i_jmp_predict(i_jmp_predict), .i_pc_inc(i_pc_inc),
        .i_flags_ie(i_flags_ie), .i_carry_en(i_carry_en), .i_alu_result(alu_result),
        .i_alu_flags(alu_flags), .o_carry(alu_carry), .o_pc(o_exec_pc), .o_flush(o_flush)
    );

    exec_result_reg #(
        .DATA_W(DATA_W), .REG_CNT(REG_CNT)
    ) exec_result_reg_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_exec_submit(exec_submit),
        .i_alu_result(alu_result), .i_r_data(r_data), .i_rf_ie(i_rf_ie),
        .i_mem_access(i_mem_access), .i_mem_we(i_mem_we), .i_mem_width(i_mem_width),
        .o_addr(o_addr), .o_data(o_data), .o_reg_ie(o_reg_ie),
        .o_mem_access(o_mem_access), .o_mem_we(o_mem_we), .o_mem_width(o_mem_width),
        .o_submit(o_submit)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES   = 3
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

    // Reset is released on a rising edge, after the last reset cycle
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

/* verification/exec_stage_tb.sv */
`timescale 1ns/1ps

module exec_stage_tb
    import isa_pkg::*;
();

    localparam int DATA_W     = 16;
    localparam int REG_CNT    = 8;
    localparam int WAIT_LIMIT = 20;

    typedef struct {
        string       name;
        alu_mode_t   mode;
        logic        use_imm;
        logic [15:0] imm;
        logic [2:0]  l_sel;
        logic [2:0]  r_sel;
        logic [1:0]  used;
        logic        flags_ie;
        logic        carry_en;
        logic [7:0]  rf_ie;
        jump_code_t  jcode;
        logic        predict;
        logic        pc_inc;
        logic        mem;
        int          stall;
    } test_t;

    logic i_clk;
    logic i_rst;
    logic i_submit;
    logic i_flush;
    logic [DATA_W-1:0] i_imm;
    logic i_jmp_predict;
    logic i_pc_inc;
    logic i_r_bus_imm;
    alu_mode_t i_alu_mode;
    logic i_carry_en;
    logic i_flags_ie;
    logic [2:0] i_l_sel;
    logic [2:0] i_r_sel;
    logic [REG_CNT-1:0] i_rf_ie;
    jump_code_t i_jump_code;
    logic i_mem_access;
    logic i_mem_we;
    logic i_mem_width;
    logic [1:0] i_used_operands;
    logic i_next_ready;
    logic [REG_CNT-1:0] i_reg_ie;
    logic [DATA_W-1:0] i_reg_data;
    logic o_ready;
    logic o_flush;
    logic [DATA_W-1:0] o_exec_pc;
    logic [DATA_W-1:0] o_addr;
    logic [DATA_W-1:0] o_data;
    logic [REG_CNT-1:0] o_reg_ie;
    logic o_mem_access;
    logic o_mem_we;
    logic o_mem_width;
    logic o_submit;

    // Expected architectural state
    logic [15:0] model_regs [REG_CNT];
    logic [4:0]  model_flags;
    logic [15:0] model_pc;
    test_t       tests [$];

    tb_clock_gen clock_gen_i (
        .o_clk(i_clk),
        .o_rst(i_rst)
    );

    exec_stage #(
        .DATA_W(DATA_W),
        .REG_CNT(REG_CNT)
    ) exec_stage_i (.*);

    // Result in the low bits, flags above it
    function automatic logic [20:0] alu_model(input alu_mode_t mode, input logic [15:0] l,
                                              input logic [15:0] r, input logic cin);
        int unsigned ul;
        int unsigned ur;
        int unsigned wide;
        int sl;
        int sr;
        int sv;
        int ci;
        int sh;
        logic [15:0] res;
        logic c;
        logic o;
        logic [4:0] f;
        ul = l;
        ur = r;
        sl = $signed(l);
        sr = $signed(r);
        sh = r % 16;
        ci = ((mode == ALU_ADC || mode == ALU_SBC) && cin) ? 1 : 0;
        c = 1'b0;
        o = 1'b0;
        case (mode)
            ALU_ADD, ALU_ADC: begin
                wide = ul + ur + ci;
                res = 16'(wide);
                c = wide > 32'hffff;
                sv = sl + sr + ci;
                o = (sv > 32767) || (sv < -32768);
            end
            ALU_SUB, ALU_SBC: begin
                res = 16'(ul - ur - ci);
                // Borrow out
                c = ul < ur + ci;
                sv = sl - sr - ci;
                o = (sv > 32767) || (sv < -32768);
            end
            ALU_AND: res = l & r;
            ALU_OR: res = l | r;
            ALU_XOR: res = l ^ r;
            ALU_SHL: res = l << sh;
            ALU_SHR: res = l >> sh;
            ALU_ASR: res = 16'(sl >>> sh);
            ALU_PASS_R: res = r;
            default: res = '0;
        endcase
        f[FLAG_C] = c;
        f[FLAG_Z] = (res == 16'h0000);
        f[FLAG_N] = res[15];
        f[FLAG_O] = o;
        f[FLAG_P] = ($countones(res) % 2) == 0;
        return {f, res};
    endfunction

    function automatic logic jump_cond_model(input jump_code_t code, input logic [4:0] f);
        logic c;
        logic z;
        logic n;
        c = f[FLAG_C];
        z = f[FLAG_Z];
        n = f[FLAG_N];
        case (code)
            JUMP_UNCOND: return 1'b1;
            JUMP_CARRY: return c;
            JUMP_EQUAL: return z;
            JUMP_LT: return n;
            JUMP_GT: return !n && !z;
            JUMP_LE: return n || z;
            JUMP_GE: return !n;
            JUMP_NE: return !z;
            JUMP_OVF: return f[FLAG_O];
            JUMP_PAR: return f[FLAG_P];
            JUMP_GTU: return !c && !z;
            JUMP_GEU: return !c;
            JUMP_LEU: return c || z;
            default: return 1'b0;
        endcase
    endfunction

    function automatic test_t alu_op(input string name, input alu_mode_t mode,
                                     input logic use_imm, input logic [15:0] imm,
                                     input logic [2:0] l_sel, input logic [2:0] r_sel,
                                     input logic flags_ie, input logic carry_en,
                                     input logic [7:0] rf_ie, input logic mem);
        test_t t;
        t = '{name: name, mode: mode, use_imm: use_imm, imm: imm, l_sel: l_sel,
              r_sel: r_sel, used: {~use_imm, 1'b1}, flags_ie: flags_ie,
              carry_en: carry_en, rf_ie: rf_ie, jcode: JUMP_NONE, predict: 1'b0,
              pc_inc: 1'b1, mem: mem, stall: 0};
        return t;
    endfunction

    // Jump target is passed through the ALU from the immediate
    function automatic test_t jump_op(input string name, input jump_code_t code,
                                      input logic predict, input logic [15:0] target);
        test_t t;
        t = alu_op(name, ALU_PASS_R, 1'b1, target, 3'd0, 3'd0, 1'b0, 1'b0, 8'h00, 1'b0);
        t.used = 2'b00;
        t.jcode = code;
        t.predict = predict;
        return t;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail %s expected %0h actual %0h", what, exp, act);
            $display("tests failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("tests failed");
        $fatal(1, "Stopped on timeout");
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        @(negedge i_clk);
        while (i_rst && n < WAIT_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (i_rst) report_timeout("reset release");
    endtask

    task automatic wait_submit(input string what, output int cycles);
        int n;
        n = 0;
        @(negedge i_clk);
        while (!o_submit && n < WAIT_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_submit) report_timeout({"o_submit of ", what});
        cycles = n;
    endtask

    task automatic write_reg(input int idx, input logic [15:0] val);
        @(posedge i_clk);
        i_reg_ie <= 8'(1 << idx);
        i_reg_data <= val;
        @(posedge i_clk);
        i_reg_ie <= '0;
        model_regs[idx] = val;
    endtask

    task automatic drive_controls(input test_t t);
        i_imm <= t.imm;
        i_jmp_predict <= t.predict;
        i_pc_inc <= t.pc_inc;
        i_r_bus_imm <= t.use_imm;
        i_alu_mode <= t.mode;
        i_carry_en <= t.carry_en;
        i_flags_ie <= t.flags_ie;
        i_l_sel <= t.l_sel;
        i_r_sel <= t.r_sel;
        i_rf_ie <= t.rf_ie;
        i_jump_code <= t.jcode;
        i_mem_access <= t.mem;
        i_mem_we <= t.mem;
        // Width bit follows the immediate so that both sizes occur
        i_mem_width <= t.imm[0];
        i_used_operands <= t.used;
    endtask

    task automatic run_test(input test_t t);
        logic [20:0] ref_out;
        logic [15:0] r_val;
        logic [15:0] exp_res;
        logic [15:0] exp_pc;
        logic cond;
        int lat;
        r_val = t.use_imm ? t.imm : model_regs[t.r_sel];
        ref_out = alu_model(t.mode, model_regs[t.l_sel], r_val,
                            t.carry_en & model_flags[FLAG_C]);
        exp_res = ref_out[15:0];
        cond = jump_cond_model(t.jcode, model_flags);
        if (t.jcode[JUMP_BIT_EN] && cond) begin
            exp_pc = exp_res;
        end else begin
            exp_pc = t.pc_inc ? model_pc + 16'd1 : model_pc;
        end
        @(posedge i_clk);
        drive_controls(t);
        i_submit <= 1'b1;
        i_next_ready <= (t.stall == 0);
        // Nothing may move while the next stage holds the instruction
        for (int k = 0; k < t.stall; k++) begin
            @(negedge i_clk);
            check_value({t.name, " o_ready in stall"}, 0, o_ready);
            check_value({t.name, " o_submit in stall"}, 0, o_submit);
            check_value({t.name, " pc in stall"}, model_pc, o_exec_pc);
            @(posedge i_clk);
            i_submit <= 1'b0;
        end
        if (t.stall > 0) i_next_ready <= 1'b1;
        @(posedge i_clk);
        i_submit <= 1'b0;
        wait_submit(t.name, lat);
        if (t.stall == 0) check_value({t.name, " latency"}, 0, lat);
        check_value({t.name, " o_addr"}, exp_res, o_addr);
        check_value({t.name, " o_data"}, t.mem ? model_regs[t.r_sel] : exp_res, o_data);
        check_value({t.name, " o_reg_ie"}, t.rf_ie, o_reg_ie);
        check_value({t.name, " o_mem_access"}, t.mem, o_mem_access);
        check_value({t.name, " o_mem_we"}, t.mem, o_mem_we);
        check_value({t.name, " o_mem_width"}, t.imm[0], o_mem_width);
        check_value({t.name, " o_flush"}, t.jcode[JUMP_BIT_EN] && (cond != t.predict),
                    o_flush);
        check_value({t.name, " o_exec_pc"}, exp_pc, o_exec_pc);
        model_pc = exp_pc;
        if (t.flags_ie) model_flags = ref_out[20:16];
        @(negedge i_clk);
        check_value({t.name, " single o_submit"}, 0, o_submit);
        check_value({t.name, " single o_flush"}, 0, o_flush);
    endtask

    // Second instruction reads the register that the first one still has pending
    task automatic hazard_test();
        test_t a;
        test_t b;
        logic [15:0] exp_a;
        logic [15:0] exp_b;
        int lat;
        a = alu_op("hazard_a", ALU_ADD, 1'b1, 16'($urandom), 3'd1, 3'd0, 1'b0, 1'b0,
                   8'h04, 1'b0);
        b = alu_op("hazard_b", ALU_ADD, 1'b1, 16'($urandom), 3'd2, 3'd0, 1'b0, 1'b0,
                   8'h00, 1'b0);
        exp_a = 16'(alu_model(ALU_ADD, model_regs[1], a.imm, 1'b0));
        exp_b = 16'(alu_model(ALU_ADD, exp_a, b.imm, 1'b0));
        @(posedge i_clk);
        drive_controls(a);
        i_submit <= 1'b1;
        @(posedge i_clk);
        drive_controls(b);
        i_reg_ie <= 8'h04;
        i_reg_data <= exp_a;
        @(negedge i_clk);
        check_value("hazard_a o_submit", 1, o_submit);
        check_value("hazard_a o_addr", exp_a, o_addr);
        check_value("hazard_b o_ready in hazard", 0, o_ready);
        @(posedge i_clk);
        i_submit <= 1'b0;
        i_reg_ie <= '0;
        model_regs[2] = exp_a;
        wait_submit("hazard_b", lat);
        check_value("hazard_b o_addr", exp_b, o_addr);
        check_value("hazard_b o_exec_pc", model_pc + 16'd2, o_exec_pc);
        model_pc = model_pc + 16'd2;
        @(negedge i_clk);
        check_value("hazard_b single o_submit", 0, o_submit);
    endtask

    task automatic flush_test();
        @(posedge i_clk);
        drive_controls(jump_op("flushed_jump", JUMP_UNCOND, 1'b0, 16'h5a5a));
        i_submit <= 1'b1;
        i_flush <= 1'b1;
        @(posedge i_clk);
        i_submit <= 1'b0;
        i_flush <= 1'b0;
        for (int k = 0; k < 4; k++) begin
            @(negedge i_clk);
            check_value("flushed_jump o_submit", 0, o_submit);
            check_value("flushed_jump o_flush", 0, o_flush);
            check_value("flushed_jump o_exec_pc", model_pc, o_exec_pc);
        end
        run_test(alu_op("after_flush", ALU_XOR, 1'b0, 16'h0000, 3'd4, 3'd5, 1'b0, 1'b0,
                        8'h20, 1'b0));
    endtask

    task automatic build_table();
        test_t t;
        jump_code_t code;
        alu_mode_t mode;
        // name, mode, use_imm, imm, l_sel, r_sel, flags_ie, carry_en, rf_ie, mem
        tests.push_back(alu_op("add_sets_carry", ALU_ADD, 1, 16'h0020, 6, 0, 1, 0, 8'h01, 0));
        tests.push_back(jump_op("jump_carry", JUMP_CARRY, 1, 16'h0100));
        tests.push_back(alu_op("adc_carry_in", ALU_ADC, 1, 16'h0020, 6, 0, 1, 1, 8'h02, 0));
        tests.push_back(alu_op("sub_equal", ALU_SUB, 1, 16'hfff0, 6, 0, 1, 0, 8'h00, 0));
        tests.push_back(jump_op("jump_equal", JUMP_EQUAL, 0, 16'h0200));
        tests.push_back(alu_op("sub_neg_ovf", ALU_SUB, 1, 16'hffff, 7, 0, 1, 0, 8'h00, 0));
        tests.push_back(jump_op("jump_lt", JUMP_LT, 1, 16'h0300));
        tests.push_back(jump_op("jump_ovf", JUMP_OVF, 0, 16'h0400));
        tests.push_back(alu_op("sbc_borrow_in", ALU_SBC, 1, 16'h0001, 7, 0, 1, 1, 8'h00, 0));
        tests.push_back(alu_op("store_word", ALU_ADD, 1, 16'h0010, 1, 3, 0, 0, 8'h00, 1));
        t = alu_op("stall_add", ALU_ADD, 0, 16'h0000, 2, 3, 0, 0, 8'h10, 0);
        t.stall = 4;
        tests.push_back(t);
        t = jump_op("stall_jump", JUMP_UNCOND, 1, 16'h0800);
        t.stall = 3;
        tests.push_back(t);
        t = alu_op("no_pc_inc", ALU_OR, 0, 16'h0000, 4, 5, 0, 0, 8'h00, 0);
        t.pc_inc = 1'b0;
        tests.push_back(t);
        // Every ALU mode, register and immediate right operand
        for (int m = 0; m <= 10; m++) begin
            mode = alu_mode_t'(m);
            tests.push_back(alu_op({mode.name(), "_reg"}, mode, 0, 16'h0000, 3'($urandom),
                                   3'($urandom), 1, 1, 8'($urandom), 0));
            tests.push_back(alu_op({mode.name(), "_imm"}, mode, 1, 16'($urandom),
                                   3'($urandom), 3'd0, 1, 1, 8'($urandom), 0));
        end
        // Zero, negative with overflow and borrow, then plain positive flags
        for (int s = 0; s < 3; s++) begin
            for (int c = 16; c <= 28; c++) begin
                code = jump_code_t'(c);
                case (s)
                    0: t = alu_op("set_zero", ALU_SUB, 1, 16'hfff0, 6, 0, 1, 0, 8'h00, 0);
                    1: t = alu_op("set_neg", ALU_SUB, 1, 16'hffff, 7, 0, 1, 0, 8'h00, 0);
                    default: t = alu_op("set_pos", ALU_SUB, 1, 16'h0001, 7, 0, 1, 0, 8'h00, 0);
                endcase
                tests.push_back(t);
                for (int p = 0; p < 2; p++) begin
                    tests.push_back(jump_op($sformatf("%s_s%0d_p%0d", code.name(), s, p),
                                            code, 1'(p), 16'($urandom)));
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h6f71));
        i_submit = 1'b0;
        i_flush = 1'b0;
        i_imm = '0;
        i_jmp_predict = 1'b0;
        i_pc_inc = 1'b0;
        i_r_bus_imm = 1'b0;
        i_alu_mode = ALU_ADD;
        i_carry_en = 1'b0;
        i_flags_ie = 1'b0;
        i_l_sel = '0;
        i_r_sel = '0;
        i_rf_ie = '0;
        i_jump_code = JUMP_NONE;
        i_mem_access = 1'b0;
        i_mem_we = 1'b0;
        i_mem_width = 1'b0;
        i_used_operands = 2'b00;
        i_next_ready = 1'b1;
        i_reg_ie = '0;
        i_reg_data = '0;
        model_flags = '0;
        model_pc = '0;
        wait_reset_done();
        check_value("reset o_exec_pc", 0, o_exec_pc);
        check_value("reset o_submit", 0, o_submit);
        check_value("reset o_flush", 0, o_flush);
        check_value("reset o_ready", 1, o_ready);
        // Registers 6 and 7 hold fixed values for the flag tests
        for (int i = 0; i < REG_CNT; i++) begin
            if (i == 6) write_reg(i, 16'hfff0);
            else if (i == 7) write_reg(i, 16'h7fff);
            else write_reg(i, 16'($urandom));
        end
        build_table();
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        hazard_test();
        flush_test();
        $display("all tests passed");
        $finish;
    end

endmodule

/* list.f */
src/cpu_cfg_pkg.sv
src/isa_pkg.sv
src/issue_ctrl.sv
src/reg_file.sv
src/alu.sv
src/branch_unit.sv
src/exec_result_reg.sv
src/exec_stage.sv
verification/tb_clock_gen.sv
verification/exec_stage_tb.sv
